// ==== flash_subsys.f ====
logic/flash_pkg.sv
logic/spi_shift_engine.sv
logic/spi_bus_arbiter.sv
logic/flash_id_reader.sv
logic/flash_data_reader.sv
logic/flash_subsys.sv
tests/spi_flash_model.sv
tests/flash_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the flash_subsys testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module flash_subsys_tb -f flash_subsys.f \
    --Mdir obj_dir -o flash_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/flash_subsys_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// ==== tests/flash_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_subsys_tb;

    localparam int SCK_HALF    = 4;
    localparam int MAX_CREDITS = 4;
    localparam int ID_CYCLES   = 1 + 48 * 2 * SCK_HALF + 2;
    localparam int TIMEOUT     = 40000;

    logic        clk;
    logic        rst_n;
    logic        fls_sck;
    logic        fls_ncs;
    logic        fls_sdo;
    logic        fls_sdi;
    logic        id_start;
    logic        id_busy;
    logic [15:0] flash_id;
    logic        rd_start;
    logic [23:0] rd_addr;
    logic [15:0] rd_len;
    logic        rd_busy;
    logic [7:0]  rd_data;
    logic        rd_valid;
    logic        rd_credit = 1'b0;

    // Scoreboard and consumer state
    logic        started;
    logic        check_order;
    logic        long_stalls;
    logic [31:0] lcg_state = 32'h242fa5cb;
    logic [23:0] rd_base;
    logic [23:0] exp_addr;
    int          rd_mark;
    int          rd_expect;
    int          byte_total = 0;
    int          returned = 0;
    int          credit_wait = 0;
    int          cycles;
    int          value_errors;
    int          rule_errors;
    int          model_errors;

    flash_subsys #(
        .SCK_HALF    (SCK_HALF),
        .MAX_CREDITS (MAX_CREDITS)
    ) i_flash_subsys (
        .clk       (clk),
        .rst_n     (rst_n),
        .fls_sck   (fls_sck),
        .fls_ncs   (fls_ncs),
        .fls_sdo   (fls_sdo),
        .fls_sdi   (fls_sdi),
        .id_start  (id_start),
        .id_busy   (id_busy),
        .flash_id  (flash_id),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .rd_len    (rd_len),
        .rd_busy   (rd_busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_credit (rd_credit)
    );

    spi_flash_model i_spi_flash_model (
        .sck         (fls_sck),
        .ncs         (fls_ncs),
        .mosi        (fls_sdo),
        .miso        (fls_sdi),
        .check_order (check_order),
        .errors      (model_errors)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic report_rule(input string what);
        $display("Error at %0t: %s", $time, what);
        rule_errors++;
    endtask

    task automatic print_counts();
        $display("Error counts: value %0d, rule %0d, flash model %0d",
                 value_errors, rule_errors, model_errors);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        print_counts();
        $display("Done: errors found");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Invariants, sampled on the falling clock edge
    //////////////////////////////////////////////////////////////////////

    // Quiet bus and idle clients until the first start
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> fls_ncs)
        else report_value("fls_ncs", 32'd1, 32'(fls_ncs));
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> !fls_sck)
        else report_value("fls_sck", 32'd0, 32'(fls_sck));
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> !fls_sdo)
        else report_value("fls_sdo", 32'd0, 32'(fls_sdo));
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> !id_busy)
        else report_value("id_busy", 32'd0, 32'(id_busy));
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> !rd_busy)
        else report_value("rd_busy", 32'd0, 32'(rd_busy));
    assert property (@(negedge clk) disable iff (!rst_n) !started |-> !rd_valid)
        else report_value("rd_valid", 32'd0, 32'(rd_valid));

    // ID result is valid from the cycle busy falls
    assert property (@(negedge clk) disable iff (!rst_n)
                     ($past(id_busy) && !id_busy) |-> flash_id == 16'hEF17)
        else report_value("flash_id", 32'hEF17, 32'(flash_id));

    assert property (@(negedge clk) disable iff (!rst_n) rd_valid |-> rd_busy)
        else report_rule("rd_valid pulsed outside a data transfer");

    // Stream scoreboard, byte n of a transfer comes from rd_base + n
    always @(negedge clk)
    begin
        if (rst_n && rd_valid)
        begin
            exp_addr = rd_base + 24'(byte_total - rd_mark);
            assert (byte_total - returned < MAX_CREDITS)
                else report_rule("rd_valid arrived with every credit outstanding");
            assert (rd_data == (exp_addr[7:0] ^ 8'hA5))
                else report_value("rd_data", 32'(exp_addr[7:0] ^ 8'hA5), 32'(rd_data));
            byte_total = byte_total + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Credit-returning consumer
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        #1;
        rd_credit = 1'b0;
        if (rst_n && byte_total > returned)
        begin
            if (credit_wait > 0)
                credit_wait = credit_wait - 1;
            else
            begin
                rd_credit = 1'b1;
                returned  = returned + 1;
                lcg_state = lcg_next(lcg_state);
                // Half of the long stalls outlast the byte time of every credit
                if (long_stalls && !lcg_state[31])
                    credit_wait = MAX_CREDITS * 16 * SCK_HALF + int'(lcg_state[23:16]);
                else if (long_stalls)
                    credit_wait = int'(lcg_state[19:16]);
                else
                    credit_wait = 0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // One-cycle start pulses, either client or both together
    task automatic start_clients(input logic do_id, input logic do_rd,
                                 input logic [23:0] addr, input logic [15:0] len);
        @(posedge clk);
        #1;
        if (do_rd)
        begin
            rd_base   = addr;
            rd_expect = int'(len);
            rd_mark   = byte_total;
        end
        rd_addr  = addr;
        rd_len   = len;
        id_start = do_id;
        rd_start = do_rd;
        started  = 1'b1;
        @(posedge clk);
        #1;
        id_start = 1'b0;
        rd_start = 1'b0;
    endtask

    task automatic wait_id_idle(output int n);
        n = 0;
        @(negedge clk);
        while (id_busy)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("id_busy to fall");
            @(negedge clk);
        end
    endtask

    task automatic wait_rd_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (rd_busy)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("rd_busy to fall");
            @(negedge clk);
        end
        assert (byte_total - rd_mark == rd_expect)
            else report_value("rd_valid pulse count", 32'(rd_expect), 32'(byte_total - rd_mark));
    endtask

    task automatic wait_credits_home();
        int n;
        n = 0;
        while (byte_total != returned)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("all credits to return");
            @(negedge clk);
        end
    endtask

    initial
    begin
        rst_n        = 1'b0;
        id_start     = 1'b0;
        rd_start     = 1'b0;
        rd_addr      = '0;
        rd_len       = '0;
        started      = 1'b0;
        check_order  = 1'b0;
        long_stalls  = 1'b0;
        rd_base      = '0;
        rd_mark      = 0;
        rd_expect    = 0;
        value_errors = 0;
        rule_errors  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle bus checked by the invariants
        repeat (20) @(posedge clk);

        // Same-cycle starts, ID reader owns the first grant after reset
        check_order = 1'b1;
        start_clients(1'b1, 1'b1, 24'h000010, 16'd6);
        wait_id_idle(cycles);
        wait_rd_idle();
        check_order = 1'b0;

        // Uncontended ID read
        start_clients(1'b1, 1'b0, 24'h000000, 16'd0);
        wait_id_idle(cycles);
        assert (cycles > 0 && cycles <= ID_CYCLES)
            else report_rule($sformatf("ID read took %0d cycles, limit is %0d",
                                       cycles, ID_CYCLES));

        // Fast consumer, low address byte wraps
        long_stalls = 1'b0;
        start_clients(1'b0, 1'b1, 24'h0001FA, 16'd16);
        wait_rd_idle();

        // Long random credit stalls
        long_stalls = 1'b1;
        start_clients(1'b0, 1'b1, 24'hABCDF0, 16'd24);
        wait_rd_idle();
        wait_credits_home();

        print_counts();
        if (value_errors + rule_errors + model_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/spi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  logic sck,
    input  logic ncs,
    input  logic mosi,
    output logic miso,
    // First frame after this rises must be the read-ID frame
    input  logic check_order,
    output int   errors
);

    import flash_pkg::*;

    int          bit_cnt;
    int          k;
    logic [31:0] cmd;
    logic [7:0]  cur;
    logic        in_frame;
    logic        order_done;

    // ID bytes, or address pattern with autoincrement
    function automatic logic [7:0] resp_byte(input logic [7:0] op, input logic [23:0] a,
                                             input int idx);
        logic [23:0] cur_addr;
        cur_addr = a + 24'(idx);
        if (op == OP_READ_ID)
            return (idx == 0) ? 8'hEF : 8'h17;
        return cur_addr[7:0] ^ 8'hA5;
    endfunction

    task automatic flag_error(input string what);
        $display("Flash model at %0t: %s", $time, what);
        errors++;
    endtask

    initial
    begin
        miso       = 1'b0;
        errors     = 0;
        bit_cnt    = 0;
        cmd        = '0;
        in_frame   = 1'b0;
        order_done = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Framing
    //////////////////////////////////////////////////////////////////////

    always @(negedge ncs)
    begin
        bit_cnt  = 0;
        in_frame = 1'b1;
        if (!check_order)
            order_done = 1'b0;
    end

    // Frame must close after the command and whole response bytes
    always @(posedge ncs)
    begin
        if (in_frame && (bit_cnt < 32 || bit_cnt % 8 != 0))
            flag_error($sformatf("frame closed after %0d SCK cycles, not on a byte boundary",
                                 bit_cnt));
        in_frame = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Command capture on rising SCK
    //////////////////////////////////////////////////////////////////////

    always @(posedge sck)
    begin
        if (ncs !== 1'b0)
            flag_error("SCK toggled while chip select was high");
        else
        begin
            if (bit_cnt < 32)
                cmd = {cmd[30:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                if (cmd[7:0] != OP_READ_ID && cmd[7:0] != OP_READ_DATA)
                    flag_error($sformatf("frame carried unknown opcode 0x%02h", cmd[7:0]));
                if (check_order && !order_done)
                begin
                    if (cmd[7:0] != OP_READ_ID)
                        flag_error("data frame was sent before the ID frame");
                    order_done = 1'b1;
                end
            end
            if (bit_cnt == 32 && cmd[31:24] == OP_READ_ID && cmd[23:0] != ID_MFR_ADDR)
                flag_error("read-ID frame carried a nonzero address");
        end
    end

    // Response bits change after falling SCK, MSB first
    always @(negedge sck)
    begin
        if (ncs === 1'b0 && bit_cnt >= 32)
        begin
            k    = bit_cnt - 32;
            cur  = resp_byte(cmd[31:24], cmd[23:0], k / 8);
            miso = cur[7 - (k % 8)];
        end
    end

endmodule

`default_nettype wire

// ==== logic/flash_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_subsys #(
    parameter int SCK_HALF    = flash_pkg::SCK_HALF_DEFAULT,
    parameter int MAX_CREDITS = flash_pkg::CREDITS_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    // Flash pins
    output logic        fls_sck,
    output logic        fls_ncs,
    output logic        fls_sdo,
    input  logic        fls_sdi,
    // ID client
    input  logic        id_start,
    output logic        id_busy,
    output logic [15:0] flash_id,
    // Data client
    input  logic        rd_start,
    input  logic [23:0] rd_addr,
    input  logic [15:0] rd_len,
    output logic        rd_busy,
    output logic [7:0]  rd_data,
    output logic        rd_valid,
    input  logic        rd_credit
);

    import flash_pkg::*;

    spi_req_t id_req;
    spi_req_t rd_req;
    spi_req_t eng_req;
    spi_rsp_t eng_rsp;
    logic     id_gnt;
    logic     rd_gnt;

    //////////////////////////////////////////////////////////////////////
    // Clients
    //////////////////////////////////////////////////////////////////////

    flash_id_reader i_flash_id_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (id_start),
        .busy     (id_busy),
        .flash_id (flash_id),
        .req      (id_req),
        .gnt      (id_gnt),
        .rsp      (eng_rsp)
    );

    flash_data_reader #(
        .MAX_CREDITS (MAX_CREDITS)
    ) i_flash_data_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (rd_start),
        .addr      (rd_addr),
        .len       (rd_len),
        .busy      (rd_busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_credit (rd_credit),
        .req       (rd_req),
        .rsp       (eng_rsp),
        .gnt       (rd_gnt)
    );

    //////////////////////////////////////////////////////////////////////
    // Shared bus
    //////////////////////////////////////////////////////////////////////

    spi_bus_arbiter i_spi_bus_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_req  (id_req),
        .rd_req  (rd_req),
        .id_gnt  (id_gnt),
        .rd_gnt  (rd_gnt),
        .eng_req (eng_req),
        .eng_rsp (eng_rsp)
    );

    // Response goes back to both clients, grant filters it
    spi_shift_engine #(
        .SCK_HALF (SCK_HALF)
    ) i_spi_shift_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (eng_req),
        .rsp     (eng_rsp),
        .fls_sck (fls_sck),
        .fls_ncs (fls_ncs),
        .fls_sdo (fls_sdo),
        .fls_sdi (fls_sdi)
    );

endmodule

`default_nettype wire

// ==== logic/flash_data_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_data_reader #(
    parameter int MAX_CREDITS = flash_pkg::CREDITS_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [23:0]         addr,
    input  logic [15:0]         len,
    output logic                busy,
    output logic [7:0]          rd_data,
    output logic                rd_valid,
    input  logic                rd_credit,
    output flash_pkg::spi_req_t req,
    input  flash_pkg::spi_rsp_t rsp,
    input  logic                gnt
);

    import flash_pkg::*;

    localparam int CW = $clog2(MAX_CREDITS + 1);

    logic [23:0]   addr_q;
    logic [15:0]   len_q;
    logic [CW-1:0] credit_cnt;
    logic          byte_in;
    logic          frame_end;
    logic          hold;

    assign byte_in   = gnt && rsp.rx_valid;
    assign frame_end = gnt && rsp.done;

    // A byte strobed this cycle has not yet left the credit count,
    // so it is taken off before the next byte is allowed to start
    assign hold = (credit_cnt <= CW'(byte_in));

    //////////////////////////////////////////////////////////////////////
    // Command
    //////////////////////////////////////////////////////////////////////

    assign req = '{
        valid:  busy,
        opcode: OP_READ_DATA,
        addr:   addr_q,
        rx_len: len_q,
        hold:   hold
    };

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (start && !busy)
            busy <= 1'b1;
        else if (frame_end)
            busy <= 1'b0;
    end

    // Address and length captured once per transfer
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            addr_q <= addr;
            len_q  <= len;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stream and credits
    //////////////////////////////////////////////////////////////////////

    // One cycle from engine strobe to consumer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= byte_in;
    end

    always_ff @(posedge clk)
    begin
        if (byte_in)
            rd_data <= rsp.rx_byte;
    end

    // Spent on forward, returned by rd_credit
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            credit_cnt <= CW'(MAX_CREDITS);
        else
        begin
            case ({rd_credit, byte_in})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/flash_id_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_id_reader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic                busy,
    output logic [15:0]         flash_id,
    output flash_pkg::spi_req_t req,
    input  logic                gnt,
    input  flash_pkg::spi_rsp_t rsp
);

    import flash_pkg::*;

    logic byte_in;
    logic frame_end;

    // Response strobes count only while this client owns the bus
    assign byte_in   = gnt && rsp.rx_valid;
    assign frame_end = gnt && rsp.done;

    //////////////////////////////////////////////////////////////////////
    // Command
    //////////////////////////////////////////////////////////////////////

    // 0x90, three zero bytes, then manufacturer and device bytes
    assign req = '{
        valid:  busy,
        opcode: OP_READ_ID,
        addr:   ID_MFR_ADDR,
        rx_len: 16'd2,
        hold:   1'b0
    };

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (start && !busy)
            busy <= 1'b1;
        else if (frame_end)
            busy <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////////////////////////

    // First byte ends up in the high half
    always_ff @(posedge clk)
    begin
        if (byte_in)
            flash_id <= {flash_id[7:0], rsp.rx_byte};
    end

endmodule

`default_nettype wire

// ==== logic/spi_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bus_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  flash_pkg::spi_req_t id_req,
    input  flash_pkg::spi_req_t rd_req,
    output logic                id_gnt,
    output logic                rd_gnt,
    output flash_pkg::spi_req_t eng_req,
    input  flash_pkg::spi_rsp_t eng_rsp
);

    // Locked owner, 0 is the ID reader, 1 the data reader
    logic owner_vld;
    logic owner_sel;
    // Round-robin pointer, set when the data reader goes first
    logic prio_rd;
    logic pick_vld;
    logic pick_sel;
    logic sel;

    // New pick only while the engine is idle
    always_comb
    begin
        pick_vld = 1'b0;
        pick_sel = 1'b0;
        if (!owner_vld && !eng_rsp.busy)
        begin
            if (prio_rd)
            begin
                pick_vld = rd_req.valid || id_req.valid;
                pick_sel = rd_req.valid;
            end
            else
            begin
                pick_vld = id_req.valid || rd_req.valid;
                pick_sel = !id_req.valid;
            end
        end
    end

    assign sel     = owner_vld ? owner_sel : pick_sel;
    assign id_gnt  = (owner_vld || pick_vld) && !sel;
    assign rd_gnt  = (owner_vld || pick_vld) && sel;
    assign eng_req = id_gnt ? id_req : (rd_gnt ? rd_req : '0);

    // Owner held for the whole frame, released on done
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            owner_vld <= 1'b0;
            owner_sel <= 1'b0;
            prio_rd   <= 1'b0;
        end
        else if (owner_vld && eng_rsp.done)
        begin
            owner_vld <= 1'b0;
            // Other client goes first next time
            prio_rd   <= ~owner_sel;
        end
        else if (pick_vld)
        begin
            owner_vld <= 1'b1;
            owner_sel <= pick_sel;
        end
    end

endmodule

`default_nettype wire

// ==== logic/spi_shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
    parameter int SCK_HALF = flash_pkg::SCK_HALF_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  flash_pkg::spi_req_t req,
    output flash_pkg::spi_rsp_t rsp,
    output logic                fls_sck,
    output logic                fls_ncs,
    output logic                fls_sdo,
    input  logic                fls_sdi
);

    localparam int PW = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

    typedef enum logic [2:0] {IDLE, SHIFT_OUT, SHIFT_IN, STALL, END} state_t;

    state_t        state;
    logic [PW-1:0] phase_cnt;
    logic [4:0]    bit_cnt;
    logic [15:0]   byte_cnt;
    logic [31:0]   tx_sr;
    logic [7:0]    rx_sr;
    logic [7:0]    rx_next;
    logic [7:0]    rx_byte_q;
    logic          rx_valid_q;
    logic          done_q;
    logic          accept;
    logic          shifting;
    logic          half_end;
    logic          sck_rise;
    logic          sck_fall;
    logic          last_tx_bit;
    logic          last_rx_bit;
    logic          last_byte;

    //////////////////////////////////////////////////////////////////////
    // Strobes
    //////////////////////////////////////////////////////////////////////

    // No new frame while the done strobe is still out
    assign accept      = (state == IDLE) && req.valid && !done_q;
    assign shifting    = (state == SHIFT_OUT) || (state == SHIFT_IN);
    assign half_end    = (phase_cnt == PW'(SCK_HALF - 1));
    assign sck_rise    = shifting && half_end && !fls_sck;
    assign sck_fall    = shifting && half_end && fls_sck;
    assign last_tx_bit = (bit_cnt == 5'd31);
    assign last_rx_bit = (bit_cnt == 5'd7);
    assign last_byte   = (byte_cnt == req.rx_len - 16'd1);
    assign rx_next     = {rx_sr[6:0], fls_sdi};

    //////////////////////////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            phase_cnt  <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            fls_sck    <= 1'b0;
            fls_ncs    <= 1'b1;
            fls_sdo    <= 1'b0;
            rx_valid_q <= 1'b0;
            done_q     <= 1'b0;
        end
        else
        begin
            rx_valid_q <= 1'b0;
            done_q     <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        // First opcode bit is set up before the first rising edge
                        state     <= SHIFT_OUT;
                        fls_ncs   <= 1'b0;
                        fls_sdo   <= req.opcode[7];
                        phase_cnt <= '0;
                        bit_cnt   <= '0;
                        byte_cnt  <= '0;
                    end
                end
                SHIFT_OUT, SHIFT_IN:
                begin
                    if (!half_end)
                    begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                    else
                    begin
                        phase_cnt <= '0;
                        fls_sck   <= ~fls_sck;
                        // Eighth rising edge of a response byte
                        if (sck_rise && state == SHIFT_IN && last_rx_bit)
                            rx_valid_q <= 1'b1;
                        if (sck_fall && state == SHIFT_OUT)
                        begin
                            fls_sdo <= tx_sr[30];
                            if (last_tx_bit)
                            begin
                                bit_cnt <= '0;
                                if (req.rx_len == 16'd0)
                                begin
                                    state   <= END;
                                    fls_ncs <= 1'b1;
                                end
                                else if (req.hold)
                                    state <= STALL;
                                else
                                    state <= SHIFT_IN;
                            end
                            else
                                bit_cnt <= bit_cnt + 5'd1;
                        end
                        if (sck_fall && state == SHIFT_IN)
                        begin
                            if (last_rx_bit)
                            begin
                                // Byte boundary, SCK is low from here
                                bit_cnt  <= '0;
                                byte_cnt <= byte_cnt + 16'd1;
                                if (last_byte)
                                begin
                                    state   <= END;
                                    fls_ncs <= 1'b1;
                                end
                                else if (req.hold)
                                    state <= STALL;
                            end
                            else
                                bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                STALL:
                begin
                    // SCK parked low, chip select kept low
                    if (!req.hold)
                        state <= SHIFT_IN;
                end
                END:
                begin
                    done_q <= 1'b1;
                    state  <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Shift registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
            tx_sr <= {req.opcode, req.addr};
        else if (sck_fall && state == SHIFT_OUT)
            tx_sr <= {tx_sr[30:0], 1'b0};
        // Flash data sampled on the rising edge
        if (sck_rise && state == SHIFT_IN)
            rx_sr <= rx_next;
        if (sck_rise && state == SHIFT_IN && last_rx_bit)
            rx_byte_q <= rx_next;
    end

    // Busy also covers the done cycle so nobody is granted early
    assign rsp = '{
        rx_byte:  rx_byte_q,
        rx_valid: rx_valid_q,
        done:     done_q,
        busy:     (state != IDLE) || done_q
    };

endmodule

`default_nettype wire

// ==== logic/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

    //////////////////////////////////////////////////////////////////////
    // SPI NOR command set
    //////////////////////////////////////////////////////////////////////

    // Only the two read-type commands are supported
    typedef enum logic [7:0] {
        OP_READ_ID   = 8'h90,
        OP_READ_DATA = 8'h03
    } flash_opcode_t;

    //////////////////////////////////////////////////////////////////////
    // Client to engine request, engine to client response
    //////////////////////////////////////////////////////////////////////

    // Request stays stable from valid until done, except hold
    typedef struct packed {
        logic          valid;
        flash_opcode_t opcode;
        logic [23:0]   addr;
        // Number of response bytes after the 32 command bits
        logic [15:0]   rx_len;
        // Pause before the next response byte
        logic          hold;
    } spi_req_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        // One strobe per received byte
        logic       rx_valid;
        // One strobe after chip select has risen
        logic       done;
        logic       busy;
    } spi_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Defaults
    //////////////////////////////////////////////////////////////////////

    // 4 clk per SCK half, so 8 clk per bit
    localparam int SCK_HALF_DEFAULT = 4;

    // Credits owned by the data reader after reset
    localparam int CREDITS_DEFAULT = 4;

    // Read-ID takes three zero address bytes
    localparam logic [23:0] ID_MFR_ADDR = 24'h000000;

endpackage

`default_nettype wire
